/* common/mandel_if.sv */
// Job and result valid/ready interfaces linking controller, escape engines and pixel writer
`timescale 1ns/1ps

// Pixel job from controller to one engine
interface pixel_job_if #(
	parameter int ADDR_W = 8
);
	import mandel_pkg::*;

	logic              valid;
	logic              ready;
	fixed_t            cr;
	fixed_t            ci;
	logic [ADDR_W-1:0] addr;

	// Controller issues, engine accepts when idle
	modport ctrl (output valid, cr, ci, addr, input ready);
	modport engine (input valid, cr, ci, addr, output ready);

endinterface

// Finished pixel from one engine to the writer
interface pixel_result_if #(
	parameter int ADDR_W = 8
);
	import mandel_pkg::*;

	logic              valid;
	logic              ready;
	logic [ADDR_W-1:0] addr;
	iter_t             count;

	// Engine holds count and address until taken
	modport engine (output valid, addr, count, input ready);
	modport writer (input valid, addr, count, output ready);

endinterface

/* common/mandel_pkg.sv */
// Shared fixed-point, count and colour types, FSM states and colour ladder; imported by all RTL
package mandel_pkg;

	////////////////////////////////////////////////////////////
	// Fixed-point format
	////////////////////////////////////////////////////////////

	// 4 integer bits, 23 fraction bits
	localparam int FRAC_BITS = 23;

	// Signed 4.23 value
	typedef logic signed [26:0] fixed_t;

	// Iteration count, also used for max_iter
	typedef logic [9:0] iter_t;

	// Packed colour, red 3 / green 3 / blue 2
	typedef logic [7:0] color_t;

	// Escape radius squared, 4.0 in 4.23
	localparam fixed_t ESCAPE_LIMIT = fixed_t'(4 << FRAC_BITS);

	////////////////////////////////////////////////////////////
	// Colour ladder
	////////////////////////////////////////////////////////////

	// Entry 0 for points inside the set
	// Entry k for count >= max_iter >> k, smallest k wins
	// Entry 8 also catches counts below every threshold
	localparam color_t COLOR_LADDER [9] = '{
		8'b000_000_00,
		8'b011_001_00,
		8'b011_001_00,
		8'b101_010_01,
		8'b011_001_01,
		8'b001_001_01,
		8'b011_010_10,
		8'b010_100_10,
		8'b010_100_10
	};

	////////////////////////////////////////////////////////////
	// FSM states
	////////////////////////////////////////////////////////////

	// Escape engine
	typedef enum logic [1:0] {
		ENG_IDLE,
		ENG_ITERATE,
		ENG_REPORT
	} engine_state_t;

	// Scan and dispatch controller
	typedef enum logic [1:0] {
		RND_IDLE,
		RND_DISPATCH,
		RND_DRAIN
	} render_state_t;

endpackage

/* compile.f */
+incdir+tests
common/mandel_pkg.sv
common/mandel_if.sv
render/render_ctrl.sv
render/escape_engine.sv
render/pixel_writer.sv
source/frame_buffer.sv
source/mandel_top.sv
tests/tb_mandel.sv

/* render/escape_engine.sv */
// Escape-time iteration engine; one z^2 + c step per clock, reports count and pixel address
`timescale 1ns/1ps

module escape_engine #(
	parameter int ADDR_W = 8
) (
	input  logic              clk,
	input  logic              rst,
	input  mandel_pkg::iter_t max_iter,
	pixel_job_if.engine       job,
	pixel_result_if.engine    result
);
	import mandel_pkg::*;

	engine_state_t     state;
	fixed_t            cr;
	fixed_t            ci;
	fixed_t            zr;
	fixed_t            zi;
	// Squares of current z, kept from the previous step
	fixed_t            zr_sq;
	fixed_t            zi_sq;
	iter_t             count;
	logic [ADDR_W-1:0] addr;

	fixed_t            zr_next;
	fixed_t            zi_next;
	fixed_t            zri;
	fixed_t            zr_sq_next;
	fixed_t            zi_sq_next;
	fixed_t            mag_next;
	iter_t             count_next;
	logic              stop;

	// Full product, arithmetic shift by the fraction, keep 27 bits
	function automatic fixed_t fx_mul(input fixed_t a, input fixed_t b);
		logic signed [53:0] full;
		full = a * b;
		return fixed_t'(full >>> FRAC_BITS);
	endfunction

	////////////////////////////////////////////////////////////
	// One iteration step
	////////////////////////////////////////////////////////////

	always_comb begin
		// zr' = zr^2 - zi^2 + cr
		zr_next    = zr_sq - zi_sq + cr;
		// zi' = 2 zr zi + ci, wraps at 27 bits
		zri        = fx_mul(zr, zi);
		zi_next    = (zri <<< 1) + ci;
		zr_sq_next = fx_mul(zr_next, zr_next);
		zi_sq_next = fx_mul(zi_next, zi_next);
		mag_next   = zr_sq_next + zi_sq_next;
		count_next = count + 1'b1;
		// Escaped or out of budget
		stop       = (mag_next > ESCAPE_LIMIT) || (count_next == max_iter);
	end

	////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= ENG_IDLE;
		end else begin
			case (state)
				ENG_IDLE:
					if (job.valid)
						state <= ENG_ITERATE;
				ENG_ITERATE:
					if (stop)
						state <= ENG_REPORT;
				// Held here while the writer is busy
				ENG_REPORT:
					if (result.ready)
						state <= ENG_IDLE;
				default: state <= ENG_IDLE;
			endcase
		end
	end

	// Datapath, load on job transfer, step while iterating
	always_ff @(posedge clk) begin
		if ((state == ENG_IDLE) && job.valid) begin
			cr    <= job.cr;
			ci    <= job.ci;
			addr  <= job.addr;
			zr    <= '0;
			zi    <= '0;
			zr_sq <= '0;
			zi_sq <= '0;
			count <= '0;
		end else if (state == ENG_ITERATE) begin
			zr    <= zr_next;
			zi    <= zi_next;
			zr_sq <= zr_sq_next;
			zi_sq <= zi_sq_next;
			count <= count_next;
		end
	end

	assign job.ready    = (state == ENG_IDLE);
	assign result.valid = (state == ENG_REPORT);
	assign result.addr  = addr;
	assign result.count = count;

endmodule

/* render/pixel_writer.sv */
// Round-robin collector of engine results; maps counts to colour and writes the frame buffer
`timescale 1ns/1ps

module pixel_writer #(
	parameter int NUM_ENGINES = 4,
	parameter int ADDR_W      = 8
) (
	input  logic               clk,
	input  logic               rst,
	input  mandel_pkg::iter_t  max_iter,
	pixel_result_if.writer     results [NUM_ENGINES],
	output logic               wr_en,
	output logic [ADDR_W-1:0]  wr_addr,
	output mandel_pkg::color_t wr_data,
	output logic               pixel_written
);
	import mandel_pkg::*;

	localparam int RW = (NUM_ENGINES > 1) ? $clog2(NUM_ENGINES) : 1;

	logic [NUM_ENGINES-1:0] valid_vec;
	logic [ADDR_W-1:0]      addr_vec [NUM_ENGINES];
	iter_t                  count_vec [NUM_ENGINES];
	logic [RW-1:0]          rr;
	logic [RW-1:0]          grant;
	logic                   found;

	// Inside the set is entry 0, else smallest passing threshold
	function automatic color_t color_of(input iter_t count, input iter_t limit);
		color_t c;
		c = COLOR_LADDER[8];
		for (int k = 8; k >= 1; k--) begin
			if (count >= (limit >> k))
				c = COLOR_LADDER[k];
		end
		if (count >= limit)
			c = COLOR_LADDER[0];
		return c;
	endfunction

	// Flatten the interface array, grant one back
	for (genvar i = 0; i < NUM_ENGINES; i++) begin : g_res
		assign valid_vec[i]     = results[i].valid;
		assign addr_vec[i]      = results[i].addr;
		assign count_vec[i]     = results[i].count;
		assign results[i].ready = found && (grant == RW'(i));
	end

	// First valid engine at or after the pointer
	always_comb begin
		int unsigned idx;
		grant = rr;
		found = 1'b0;
		for (int k = 0; k < NUM_ENGINES; k++) begin
			idx = (int'(rr) + k) % NUM_ENGINES;
			if (!found && valid_vec[idx]) begin
				found = 1'b1;
				grant = RW'(idx);
			end
		end
	end

	// Pointer moves past the engine just served
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			rr <= '0;
		else if (found)
			rr <= (grant == RW'(NUM_ENGINES - 1)) ? '0 : grant + 1'b1;
	end

	// Write lands on the transfer edge
	assign wr_en         = found;
	assign wr_addr       = addr_vec[grant];
	assign wr_data       = color_of(count_vec[grant], max_iter);
	assign pixel_written = found;

endmodule

/* render/render_ctrl.sv */
// Raster scan controller; steps pixel coordinates, issues jobs round-robin, times the render
`timescale 1ns/1ps

module render_ctrl #(
	parameter int NUM_ENGINES = 4,
	parameter int IMG_W       = 16,
	parameter int IMG_H       = 12,
	parameter int ADDR_W      = 8
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               start,
	input  mandel_pkg::fixed_t cr_start,
	input  mandel_pkg::fixed_t ci_start,
	input  mandel_pkg::fixed_t dx,
	input  mandel_pkg::fixed_t dy,
	input  logic               pixel_written,
	output logic               busy,
	output logic               done,
	output logic [31:0]        render_cycles,
	pixel_job_if.ctrl          jobs [NUM_ENGINES]
);
	import mandel_pkg::*;

	localparam int XW = (IMG_W > 1) ? $clog2(IMG_W) : 1;
	localparam int YW = (IMG_H > 1) ? $clog2(IMG_H) : 1;
	localparam int RW = (NUM_ENGINES > 1) ? $clog2(NUM_ENGINES) : 1;
	localparam logic [ADDR_W-1:0] LAST_PIX = ADDR_W'(IMG_W * IMG_H - 1);

	render_state_t          state;
	// View latched at start
	fixed_t                 cr_row;
	fixed_t                 dx_r;
	fixed_t                 dy_r;
	// Coordinate of the pending job
	fixed_t                 cr_run;
	fixed_t                 ci_run;
	logic [XW-1:0]          x;
	logic [YW-1:0]          y;
	logic [ADDR_W-1:0]      addr;
	logic [ADDR_W-1:0]      written;
	logic [RW-1:0]          rr;
	logic [NUM_ENGINES-1:0] ready_vec;
	logic                   issue;
	logic                   row_end;
	logic                   last_job;
	logic                   last_write;

	////////////////////////////////////////////////////////////
	// Job fan-out
	////////////////////////////////////////////////////////////

	// Payload shared, valid only to the engine under the pointer
	for (genvar i = 0; i < NUM_ENGINES; i++) begin : g_job
		assign jobs[i].valid = (state == RND_DISPATCH) && (rr == RW'(i));
		assign jobs[i].cr    = cr_run;
		assign jobs[i].ci    = ci_run;
		assign jobs[i].addr  = addr;
		assign ready_vec[i]  = jobs[i].ready;
	end

	assign issue      = (state == RND_DISPATCH) && ready_vec[rr];
	assign row_end    = (x == XW'(IMG_W - 1));
	assign last_job   = row_end && (y == YW'(IMG_H - 1));
	// Final pixel lands this cycle
	assign last_write = pixel_written && (written == LAST_PIX);

	////////////////////////////////////////////////////////////
	// Scan FSM and counters
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state         <= RND_IDLE;
			x             <= '0;
			y             <= '0;
			addr          <= '0;
			written       <= '0;
			rr            <= '0;
			busy          <= 1'b0;
			done          <= 1'b0;
			render_cycles <= '0;
		end else begin
			done <= 1'b0;
			// One tick per busy cycle
			if (busy)
				render_cycles <= render_cycles + 32'd1;
			if (busy && pixel_written)
				written <= written + 1'b1;
			case (state)
				RND_IDLE: begin
					// Start ignored unless idle
					if (start) begin
						state         <= RND_DISPATCH;
						busy          <= 1'b1;
						x             <= '0;
						y             <= '0;
						addr          <= '0;
						written       <= '0;
						rr            <= '0;
						render_cycles <= '0;
					end
				end
				RND_DISPATCH: begin
					if (issue) begin
						rr   <= (rr == RW'(NUM_ENGINES - 1)) ? '0 : rr + 1'b1;
						addr <= addr + 1'b1;
						if (row_end) begin
							x <= '0;
							y <= y + 1'b1;
						end else begin
							x <= x + 1'b1;
						end
						if (last_job)
							state <= RND_DRAIN;
					end
				end
				RND_DRAIN: begin
					// Wait for the engines to empty
					if (last_write) begin
						state <= RND_IDLE;
						busy  <= 1'b0;
						done  <= 1'b1;
					end
				end
				default: state <= RND_IDLE;
			endcase
		end
	end

	// Running coordinate, cr by dx per column, ci down by dy per row
	always_ff @(posedge clk) begin
		if ((state == RND_IDLE) && start) begin
			cr_row <= cr_start;
			dx_r   <= dx;
			dy_r   <= dy;
			cr_run <= cr_start;
			ci_run <= ci_start;
		end else if (issue) begin
			if (row_end) begin
				cr_run <= cr_row;
				ci_run <= ci_run - dy_r;
			end else begin
				cr_run <= cr_run + dx_r;
			end
		end
	end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build the renderer testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_mandel \
	-Mdir obj_dir -o sim_mandel || { echo "Build failed"; exit 1; }
./obj_dir/sim_mandel > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log
grep -q "Test completed successfully" sim.log && echo "Simulation passed" || {
	echo "Simulation did not pass"
	exit 1
}

/* source/frame_buffer.sv */
// Pixel memory with one write port and one registered read port, readable during a render
`timescale 1ns/1ps

module frame_buffer #(
	parameter int DEPTH  = 192,
	parameter int ADDR_W = 8
) (
	input  logic               clk,
	input  logic               wr_en,
	input  logic [ADDR_W-1:0]  wr_addr,
	input  mandel_pkg::color_t wr_data,
	input  logic [ADDR_W-1:0]  rd_addr,
	output mandel_pkg::color_t rd_data
);
	import mandel_pkg::*;

	color_t mem [DEPTH];

	// Read returns old data on a same-address write
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		rd_data <= mem[rd_addr];
	end

endmodule

/* source/mandel_top.sv */
// Mandelbrot renderer top level; plain ports, wires controller, engines, writer and frame buffer
`timescale 1ns/1ps

module mandel_top #(
	parameter int NUM_ENGINES = 4,
	parameter int IMG_W       = 16,
	parameter int IMG_H       = 12,
	localparam int ADDR_W     = $clog2(IMG_W * IMG_H)
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               start,
	input  mandel_pkg::fixed_t cr_start,
	input  mandel_pkg::fixed_t ci_start,
	input  mandel_pkg::fixed_t dx,
	input  mandel_pkg::fixed_t dy,
	input  mandel_pkg::iter_t  max_iter,
	input  logic [ADDR_W-1:0]  rd_addr,
	output logic               busy,
	output logic               done,
	output logic [31:0]        render_cycles,
	output mandel_pkg::color_t rd_data
);
	import mandel_pkg::*;

	// Iteration budget for the current render
	iter_t             max_iter_r;
	logic              pixel_written;
	logic              wr_en;
	logic [ADDR_W-1:0] wr_addr;
	color_t            wr_data;

	pixel_job_if    #(.ADDR_W(ADDR_W)) job_bus [NUM_ENGINES] ();
	pixel_result_if #(.ADDR_W(ADDR_W)) res_bus [NUM_ENGINES] ();

	// Same condition the controller uses to accept a start
	always_ff @(posedge clk) begin
		if (start && !busy)
			max_iter_r <= max_iter;
	end

	////////////////////////////////////////////////////////////
	// Controller, engines, writer, memory
	////////////////////////////////////////////////////////////

	render_ctrl #(
		.NUM_ENGINES (NUM_ENGINES),
		.IMG_W       (IMG_W),
		.IMG_H       (IMG_H),
		.ADDR_W      (ADDR_W)
	) u_ctrl (
		.clk           (clk),
		.rst           (rst),
		.start         (start),
		.cr_start      (cr_start),
		.ci_start      (ci_start),
		.dx            (dx),
		.dy            (dy),
		.pixel_written (pixel_written),
		.busy          (busy),
		.done          (done),
		.render_cycles (render_cycles),
		.jobs          (job_bus)
	);

	for (genvar i = 0; i < NUM_ENGINES; i++) begin : g_engine
		escape_engine #(.ADDR_W(ADDR_W)) u_engine (
			.clk      (clk),
			.rst      (rst),
			.max_iter (max_iter_r),
			.job      (job_bus[i]),
			.result   (res_bus[i])
		);
	end

	pixel_writer #(
		.NUM_ENGINES (NUM_ENGINES),
		.ADDR_W      (ADDR_W)
	) u_writer (
		.clk           (clk),
		.rst           (rst),
		.max_iter      (max_iter_r),
		.results       (res_bus),
		.wr_en         (wr_en),
		.wr_addr       (wr_addr),
		.wr_data       (wr_data),
		.pixel_written (pixel_written)
	);

	frame_buffer #(
		.DEPTH  (IMG_W * IMG_H),
		.ADDR_W (ADDR_W)
	) u_fb (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

endmodule

/* tests/mandel_ref.svh */
// Reference model for the renderer testbench; fixed-point multiply, escape count, colour ladder
`ifndef MANDEL_REF_SVH
`define MANDEL_REF_SVH

// Whole product, arithmetic shift right by the fraction bits, keep 27 bits
function automatic fixed_t fixed_mul(input fixed_t a, input fixed_t b);
	longint prod;
	prod = longint'(a) * longint'(b);
	return fixed_t'(prod >>> FRAC_BITS);
endfunction

// Escape-time count for one point, z starts at zero
function automatic iter_t escape_count(input fixed_t cr, input fixed_t ci, input iter_t limit);
	fixed_t zr;
	fixed_t zi;
	fixed_t zr_n;
	fixed_t zi_n;
	fixed_t mag;
	int     n;
	bit     stop;
	zr   = '0;
	zi   = '0;
	n    = 0;
	stop = 1'b0;
	while (!stop) begin
		zr_n = fixed_mul(zr, zr) - fixed_mul(zi, zi) + cr;
		// Doubling wraps at 27 bits like any other sum
		zi_n = fixed_mul(zr, zi) + fixed_mul(zr, zi) + ci;
		n++;
		mag = fixed_mul(zr_n, zr_n) + fixed_mul(zi_n, zi_n);
		if ((mag > ESCAPE_LIMIT) || (n == int'(limit)))
			stop = 1'b1;
		zr = zr_n;
		zi = zi_n;
	end
	return iter_t'(n);
endfunction

// Inside the set is entry 0, then the smallest k with count >= limit >> k
function automatic color_t ladder_color(input iter_t count, input iter_t limit);
	color_t c;
	bit     hit;
	if (count == limit)
		return COLOR_LADDER[0];
	c   = COLOR_LADDER[8];
	hit = 1'b0;
	for (int k = 1; k <= 8; k++) begin
		if (!hit && (count >= (limit >> k))) begin
			c   = COLOR_LADDER[k];
			hit = 1'b1;
		end
	end
	return c;
endfunction

`endif

/* tests/tb_mandel.sv */
// Testbench for the Mandelbrot renderer; renders a table of views, reads the frame back, checks it
`timescale 1ns/1ps

module tb_mandel;
	import mandel_pkg::*;

	`include "mandel_ref.svh"

	localparam int IMG_W          = 16;
	localparam int IMG_H          = 12;
	localparam int NUM_PIX        = IMG_W * IMG_H;
	localparam int ADDR_W         = $clog2(NUM_PIX);
	localparam int NUM_VIEWS      = 4;
	localparam int RENDER_TIMEOUT = 200000;
	localparam int MID_START_AT   = 20;
	localparam int QUIET_CYCLES   = 40;

	logic              clk;
	logic              rst;
	logic              start;
	fixed_t            cr_start;
	fixed_t            ci_start;
	fixed_t            dx;
	fixed_t            dy;
	iter_t             max_iter;
	logic [ADDR_W-1:0] rd_addr;
	logic              busy;
	logic              done;
	logic [31:0]       render_cycles;
	color_t            rd_data;

	////////////////////////////////////////////////////////////
	// View table
	////////////////////////////////////////////////////////////

	string  view_name [NUM_VIEWS];
	fixed_t view_cr [NUM_VIEWS];
	fixed_t view_ci [NUM_VIEWS];
	fixed_t view_dx [NUM_VIEWS];
	fixed_t view_dy [NUM_VIEWS];
	iter_t  view_iter [NUM_VIEWS];
	// Second start mid-render
	bit     view_mid [NUM_VIEWS];
	// View must hold points inside the set
	bit     view_inside [NUM_VIEWS];

	color_t exp_img [NUM_PIX];
	int     read_order [NUM_PIX];
	int     busy_seen;
	int     done_seen;

	mandel_top dut (
		.clk           (clk),
		.rst           (rst),
		.start         (start),
		.cr_start      (cr_start),
		.ci_start      (ci_start),
		.dx            (dx),
		.dy            (dy),
		.max_iter      (max_iter),
		.rd_addr       (rd_addr),
		.busy          (busy),
		.done          (done),
		.render_cycles (render_cycles),
		.rd_data       (rd_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Inputs move and outputs are sampled 1 ns past the edge
	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic fail_value(input string name, input longint exp, input longint act);
		$display("[FAIL] %s expected 0x%0h actual 0x%0h", name, exp, act);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic fail_text(input string what);
		$display("Error: %s", what);
		$display("Test failed");
		$fatal(1);
	endtask

	// Thousandths to 4.23
	function automatic fixed_t from_milli(input int m);
		return fixed_t'((longint'(m) * 64'sd8388608) / 64'sd1000);
	endfunction

	task automatic set_view(input int row, input string name, input int cr_m, input int ci_m,
			input int dx_m, input int dy_m, input int iters, input bit mid, input bit in_set);
		view_name[row]   = name;
		view_cr[row]     = from_milli(cr_m);
		view_ci[row]     = from_milli(ci_m);
		view_dx[row]     = from_milli(dx_m);
		view_dy[row]     = from_milli(dy_m);
		view_iter[row]   = iter_t'(iters);
		view_mid[row]    = mid;
		view_inside[row] = in_set;
	endtask

	task automatic load_views();
		set_view(0, "whole_set", -2000, 1200, 187, 200, 64, 1'b0, 1'b1);
		set_view(1, "boundary_zoom", -800, 200, 5, 5, 100, 1'b1, 1'b0);
		set_view(2, "low_iter", -2100, 1100, 180, 180, 8, 1'b0, 1'b1);
		set_view(3, "deep_iter", -750, 120, 10, 10, 255, 1'b1, 1'b1);
	endtask

	task automatic drive_view(input int row);
		cr_start = view_cr[row];
		ci_start = view_ci[row];
		dx       = view_dx[row];
		dy       = view_dy[row];
		max_iter = view_iter[row];
	endtask

	// Model image with cr stepped by x*dx and ci by -y*dy
	task automatic build_expected(input int row);
		fixed_t cr;
		fixed_t ci;
		iter_t  n;
		int     n_inside;
		n_inside = 0;
		for (int y = 0; y < IMG_H; y++) begin
			for (int x = 0; x < IMG_W; x++) begin
				cr = view_cr[row] + fixed_t'(longint'(x) * longint'(view_dx[row]));
				ci = view_ci[row] - fixed_t'(longint'(y) * longint'(view_dy[row]));
				n  = escape_count(cr, ci, view_iter[row]);
				exp_img[y * IMG_W + x] = ladder_color(n, view_iter[row]);
				if (n == view_iter[row])
					n_inside++;
			end
		end
		assert (!view_inside[row] || (n_inside > 0))
		else fail_text({view_name[row], " has no point inside the set in the model"});
	endtask

	////////////////////////////////////////////////////////////
	// Render and readback
	////////////////////////////////////////////////////////////

	task automatic render_view(input int row);
		int          cycles;
		bit          finished;
		logic [31:0] held;
		drive_view(row);
		start = 1'b1;
		tick();
		start = 1'b0;
		assert (busy == 1'b1) else fail_value({view_name[row], " busy after start"}, 1, busy);
		cycles    = 0;
		finished  = 1'b0;
		busy_seen = 0;
		done_seen = 0;
		while (!finished) begin
			if (busy)
				busy_seen++;
			if (done) begin
				done_seen++;
				finished = 1'b1;
				assert (busy == 1'b0)
				else fail_value({view_name[row], " busy with done"}, 0, busy);
			end else begin
				if (view_mid[row] && (cycles == MID_START_AT)) begin
					// Another view requested while busy
					start    = 1'b1;
					cr_start = '0;
					ci_start = '0;
					dx       = from_milli(50);
					dy       = from_milli(50);
					max_iter = iter_t'(3);
				end else if (start) begin
					start = 1'b0;
					drive_view(row);
				end
				cycles++;
				assert (cycles < RENDER_TIMEOUT)
				else fail_text({view_name[row], " render did not finish in time"});
				tick();
			end
		end
		start = 1'b0;
		held  = render_cycles;
		assert (render_cycles == 32'(busy_seen))
		else fail_value({view_name[row], " render_cycles"}, busy_seen, render_cycles);
		// Done is a single pulse and nothing follows it
		for (int i = 0; i < QUIET_CYCLES; i++) begin
			tick();
			if (done)
				done_seen++;
			assert (busy == 1'b0) else fail_value({view_name[row], " busy after done"}, 0, busy);
		end
		assert (done_seen == 1) else fail_value({view_name[row], " done pulses"}, 1, done_seen);
		assert (render_cycles == held)
		else fail_value({view_name[row], " render_cycles hold"}, held, render_cycles);
	endtask

	// Random readback order over every address
	task automatic shuffle_order();
		int j;
		int t;
		for (int i = 0; i < NUM_PIX; i++)
			read_order[i] = i;
		for (int i = NUM_PIX - 1; i > 0; i--) begin
			j = int'($urandom % 32'(i + 1));
			t = read_order[i];
			read_order[i] = read_order[j];
			read_order[j] = t;
		end
	endtask

	task automatic check_frame(input int row);
		int a;
		shuffle_order();
		for (int i = 0; i < NUM_PIX; i++) begin
			a = read_order[i];
			rd_addr = ADDR_W'(a);
			tick();
			assert (rd_data == exp_img[a])
			else fail_value($sformatf("%s pixel %0d", view_name[row], a), exp_img[a], rd_data);
		end
		assert (render_cycles == 32'(busy_seen))
		else fail_value({view_name[row], " render_cycles after read"}, busy_seen, render_cycles);
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(31));
		rst      = 1'b1;
		start    = 1'b0;
		cr_start = '0;
		ci_start = '0;
		dx       = '0;
		dy       = '0;
		max_iter = '0;
		rd_addr  = '0;
		load_views();
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		tick();
		assert (busy == 1'b0) else fail_value("reset busy", 0, busy);
		assert (done == 1'b0) else fail_value("reset done", 0, done);
		assert (render_cycles == 32'd0) else fail_value("reset render_cycles", 0, render_cycles);
		for (int row = 0; row < NUM_VIEWS; row++) begin
			build_expected(row);
			render_view(row);
			check_frame(row);
		end
		$display("Test completed successfully");
		$finish;
	end

endmodule
